//--- hdl/fetch_pkg.sv
package fetch_pkg;

	// ------------------------------------------------------------
	// opcode classes and major opcodes
	// ------------------------------------------------------------

	typedef enum logic [3:0] {
		OP_LOAD,
		OP_STORE,
		OP_BRANCH,
		OP_JAL,
		OP_JALR,
		OP_OP,
		OP_OP_IMM,
		OP_LUI,
		OP_AUIPC,
		OP_SYSTEM,
		OP_COMPRESSED,
		OP_OTHER
	} op_class_e;

	// bits 6:2 of a 32-bit instruction.
	typedef enum logic [4:0] {
		OPC_LOAD   = 5'b00000,
		OPC_STORE  = 5'b01000,
		OPC_BRANCH = 5'b11000,
		OPC_JAL    = 5'b11011,
		OPC_JALR   = 5'b11001,
		OPC_OP     = 5'b01100,
		OPC_OP_IMM = 5'b00100,
		OPC_LUI    = 5'b01101,
		OPC_AUIPC  = 5'b00101,
		OPC_SYSTEM = 5'b11100
	} rv_opcode_e;

	// ------------------------------------------------------------
	// datapath structs
	// ------------------------------------------------------------

	typedef struct packed {
		logic        valid;
		logic [31:0] rdata;
		logic        err;
	} mem_rsp_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        err;
	} fifo_entry_t;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] addr;
		logic        err;
		logic        err_plus2; // only the second word faulted.
	} fifo_out_t;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] addr;
		logic        err;
		logic        err_plus2;
		logic        is_compressed;
		op_class_e   op_class;
	} fetch_out_t;

endpackage

//--- hdl/fetch_req_ctrl.sv
`timescale 1ns/1ps

module fetch_req_ctrl
	import fetch_pkg::*;
#(
	parameter int NUM_REQS = 2
) (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                fetch_en_i,
	input  logic                redirect_i,
	input  logic [31:0]         redirect_addr_i,
	input  logic [NUM_REQS-1:0] fifo_busy_i,
	output logic                mem_req_o,
	output logic [31:0]         mem_addr_o,
	input  logic                mem_gnt_i,
	input  mem_rsp_t            mem_rsp_i,
	output mem_rsp_t            fifo_in_o,
	output logic                fifo_clear_o
);

	localparam int CNT_W = $clog2(NUM_REQS + 1);

	logic [31:2]      fetch_addr_q;
	logic [CNT_W-1:0] outstanding_q;
	logic [CNT_W-1:0] outstanding_d;
	logic [CNT_W-1:0] discard_q;
	logic [CNT_W-1:0] discard_d;
	logic             room;
	logic             req_accept;
	logic             rsp_stale;

	// ------------------------------------------------------------
	// request side
	// ------------------------------------------------------------

	// outstanding plus buffered words must leave space for every response.
	assign room = (int'(outstanding_q) + $countones(fifo_busy_i)) < NUM_REQS;

	// held off in the redirect cycle, target goes out next cycle.
	assign mem_req_o  = fetch_en_i & room & ~redirect_i;
	assign mem_addr_o = {fetch_addr_q, 2'b00};
	assign req_accept = mem_req_o & mem_gnt_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			fetch_addr_q <= '0;
		end else if (redirect_i) begin
			fetch_addr_q <= redirect_addr_i[31:2];
		end else if (req_accept) begin
			fetch_addr_q <= fetch_addr_q + 30'd1;
		end
	end

	// ------------------------------------------------------------
	// response side
	// ------------------------------------------------------------

	assign rsp_stale = (discard_q != '0);

	always_comb begin
		fifo_in_o       = mem_rsp_i;
		fifo_in_o.valid = mem_rsp_i.valid & ~rsp_stale & ~redirect_i;
	end

	assign fifo_clear_o = redirect_i;

	always_comb begin
		outstanding_d = outstanding_q + CNT_W'(req_accept) - CNT_W'(mem_rsp_i.valid);
		if (redirect_i) begin
			discard_d = outstanding_d; // everything still in flight is stale.
		end else if (mem_rsp_i.valid && rsp_stale) begin
			discard_d = discard_q - 1'b1;
		end else begin
			discard_d = discard_q;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			outstanding_q <= '0;
			discard_q     <= '0;
		end else begin
			outstanding_q <= outstanding_d;
			discard_q     <= discard_d;
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	a_outstanding_bound: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		int'(outstanding_q) <= NUM_REQS
	);

	// memory sees a steady address until it grants.
	a_addr_stable: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		mem_req_o && !mem_gnt_i |=> $stable(mem_addr_o)
	);

endmodule

//--- hdl/fetch_fifo.sv
`timescale 1ns/1ps

module fetch_fifo
	import fetch_pkg::*;
#(
	parameter int NUM_REQS = 2
) (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                clear_i,
	input  logic [31:0]         redirect_addr_i,
	output logic [NUM_REQS-1:0] busy_o,
	input  mem_rsp_t            in_i,
	output logic                out_valid_o,
	input  logic                out_ready_i,
	output fifo_out_t           out_o
);

	localparam int DEPTH = NUM_REQS + 1;

	fifo_entry_t [DEPTH-1:0] entry_q;
	fifo_entry_t [DEPTH-1:0] entry_d;
	fifo_entry_t [DEPTH:0]   entry_src;
	fifo_entry_t             in_entry;
	fifo_entry_t             head;
	fifo_entry_t             second;
	logic [DEPTH-1:0]        valid_q;
	logic [DEPTH-1:0]        valid_d;
	logic [DEPTH-1:0]        valid_pushed;
	logic [DEPTH:0]          pushed_ext;
	logic [DEPTH-1:0]        lowest_free;
	logic [DEPTH-1:0]        entry_en;
	logic [31:1]             instr_addr_q;
	logic [31:1]             instr_addr_next;
	logic                    aligned_is_c;
	logic                    unaligned_is_c;
	logic                    valid_any;
	logic                    valid_pair;
	logic                    err_pair;
	logic                    incr_two;
	logic                    out_fire;
	logic                    pop_fifo;

	// ------------------------------------------------------------
	// output word selection, with bypass from the input
	// ------------------------------------------------------------

	assign in_entry = '{rdata: in_i.rdata, err: in_i.err};
	assign head     = valid_q[0] ? entry_q[0] : in_entry;
	assign second   = valid_q[1] ? entry_q[1] : in_entry;

	assign aligned_is_c   = (head.rdata[1:0] != 2'b11);
	assign unaligned_is_c = (head.rdata[17:16] != 2'b11);

	assign valid_any  = valid_q[0] | in_i.valid;
	assign valid_pair = valid_q[1] | (valid_q[0] & in_i.valid);
	assign err_pair   = head.err | (second.err & ~unaligned_is_c); // second word only if touched.

	always_comb begin
		out_o.addr = {instr_addr_q, 1'b0};
		if (instr_addr_q[1]) begin
			out_o.instr     = {second.rdata[15:0], head.rdata[31:16]};
			out_o.err       = err_pair;
			out_o.err_plus2 = err_pair & ~head.err;
			out_valid_o     = (unaligned_is_c ? valid_any : valid_pair) & ~clear_i;
		end else begin
			out_o.instr     = head.rdata;
			out_o.err       = head.err;
			out_o.err_plus2 = 1'b0;
			out_valid_o     = valid_any & ~clear_i;
		end
	end

	assign out_fire = out_valid_o & out_ready_i;

	// ------------------------------------------------------------
	// instruction address
	// ------------------------------------------------------------

	assign incr_two        = instr_addr_q[1] ? unaligned_is_c : aligned_is_c;
	assign instr_addr_next = instr_addr_q + (incr_two ? 31'd1 : 31'd2);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			instr_addr_q <= '0;
		end else if (clear_i) begin
			instr_addr_q <= redirect_addr_i[31:1];
		end else if (out_fire) begin
			instr_addr_q <= instr_addr_next;
		end
	end

	// ------------------------------------------------------------
	// shift-down queue
	// ------------------------------------------------------------

	// head word is done once its upper half has gone out.
	assign pop_fifo = out_fire & (instr_addr_q[1] | ~aligned_is_c);

	assign lowest_free  = ~valid_q & {valid_q[DEPTH-2:0], 1'b1};
	assign valid_pushed = valid_q | (lowest_free & {DEPTH{in_i.valid}});
	assign pushed_ext   = {1'b0, valid_pushed};

	always_comb begin
		entry_src[DEPTH] = in_entry;
		valid_d          = pop_fifo ? (valid_pushed >> 1) : valid_pushed;
		if (clear_i) begin
			valid_d = '0;
		end
		for (int i = 0; i < DEPTH; i++) begin
			entry_src[i] = valid_q[i] ? entry_q[i] : in_entry;
		end
		for (int i = 0; i < DEPTH; i++) begin
			if (pop_fifo) begin
				entry_en[i] = pushed_ext[i+1];
				entry_d[i]  = entry_src[i+1]; // move down one slot.
			end else begin
				entry_en[i] = in_i.valid & lowest_free[i];
				entry_d[i]  = in_entry;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
			entry_q <= '0;
		end else begin
			valid_q <= valid_d;
			for (int i = 0; i < DEPTH; i++) begin
				if (entry_en[i]) begin
					entry_q[i] <= entry_d[i];
				end
			end
		end
	end

	assign busy_o = valid_q[DEPTH-1:1];

	// request flow control must keep a slot free for every response.
	a_no_overflow: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		in_i.valid |-> !(&valid_q)
	);

endmodule

//--- hdl/instr_predecode.sv
`timescale 1ns/1ps

module instr_predecode
	import fetch_pkg::*;
(
	input  logic       fifo_valid_i,
	output logic       fifo_ready_o,
	input  fifo_out_t  fifo_i,
	output logic       out_valid_o,
	input  logic       out_ready_i,
	output fetch_out_t out_o
);

	logic      is_compressed;
	op_class_e op_class;

	// pure labelling, the handshake passes straight through.
	assign out_valid_o  = fifo_valid_i;
	assign fifo_ready_o = out_ready_i;

	assign is_compressed = (fifo_i.instr[1:0] != 2'b11);

	// ------------------------------------------------------------
	// opcode class
	// ------------------------------------------------------------

	always_comb begin
		if (fifo_i.err) begin
			op_class = OP_OTHER;
		end else if (is_compressed) begin
			op_class = OP_COMPRESSED;
		end else begin
			case (fifo_i.instr[6:2])
				OPC_LOAD:   op_class = OP_LOAD;
				OPC_STORE:  op_class = OP_STORE;
				OPC_BRANCH: op_class = OP_BRANCH;
				OPC_JAL:    op_class = OP_JAL;
				OPC_JALR:   op_class = OP_JALR;
				OPC_OP:     op_class = OP_OP;
				OPC_OP_IMM: op_class = OP_OP_IMM;
				OPC_LUI:    op_class = OP_LUI;
				OPC_AUIPC:  op_class = OP_AUIPC;
				OPC_SYSTEM: op_class = OP_SYSTEM;
				default:    op_class = OP_OTHER;
			endcase
		end
	end

	// ------------------------------------------------------------
	// output
	// ------------------------------------------------------------

	always_comb begin
		out_o.instr = fifo_i.instr;
		if (is_compressed) begin
			out_o.instr[31:16] = 16'h0000; // upper half belongs to the next one.
		end
		out_o.addr          = fifo_i.addr;
		out_o.err           = fifo_i.err;
		out_o.err_plus2     = fifo_i.err_plus2;
		out_o.is_compressed = is_compressed;
		out_o.op_class      = op_class;
	end

endmodule

//--- hdl/prefetch_top.sv
`timescale 1ns/1ps

module prefetch_top
	import fetch_pkg::*;
#(
	parameter int NUM_REQS = 2
) (
	input  logic        clk_i,
	input  logic        rst_ni,
	// core side
	input  logic        fetch_en_i,
	input  logic        redirect_i,
	input  logic [31:0] redirect_addr_i,
	output logic        out_valid_o,
	input  logic        out_ready_i,
	output fetch_out_t  out_instr_o,
	// memory side
	output logic        mem_req_o,
	output logic [31:0] mem_addr_o,
	input  logic        mem_gnt_i,
	input  mem_rsp_t    mem_rsp_i
);

	mem_rsp_t            fifo_in;
	logic                fifo_clear;
	logic [NUM_REQS-1:0] fifo_busy;
	fifo_out_t           fifo_out;
	logic                fifo_valid;
	logic                fifo_ready;

	fetch_req_ctrl #(
		.NUM_REQS(NUM_REQS)
	) req_ctrl_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.fetch_en_i     (fetch_en_i),
		.redirect_i     (redirect_i),
		.redirect_addr_i(redirect_addr_i),
		.fifo_busy_i    (fifo_busy),
		.mem_req_o      (mem_req_o),
		.mem_addr_o     (mem_addr_o),
		.mem_gnt_i      (mem_gnt_i),
		.mem_rsp_i      (mem_rsp_i),
		.fifo_in_o      (fifo_in),
		.fifo_clear_o   (fifo_clear)
	);

	fetch_fifo #(
		.NUM_REQS(NUM_REQS)
	) fifo_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.clear_i        (fifo_clear),
		.redirect_addr_i(redirect_addr_i),
		.busy_o         (fifo_busy),
		.in_i           (fifo_in),
		.out_valid_o    (fifo_valid),
		.out_ready_i    (fifo_ready),
		.out_o          (fifo_out)
	);

	instr_predecode predecode_i (
		.fifo_valid_i(fifo_valid),
		.fifo_ready_o(fifo_ready),
		.fifo_i      (fifo_out),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_o       (out_instr_o)
	);

endmodule

//--- test/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
	import fetch_pkg::*;
#(
	parameter logic [31:0] ERR_LO = 32'h0,
	parameter logic [31:0] ERR_HI = 32'h0
) (
	input  logic        clk_i,
	input  logic        rst_ni,
	input  logic [31:0] rnd_i,
	input  logic        mem_req_i,
	input  logic [31:0] mem_addr_i,
	output logic        mem_gnt_o,
	output mem_rsp_t    mem_rsp_o,
	output int          inflight_o,
	input  logic [31:0] peek_lo_addr_i,
	input  logic [31:0] peek_hi_addr_i,
	output mem_rsp_t    peek_lo_o,
	output mem_rsp_t    peek_hi_o
);

	logic [31:0] addr_q[$];
	int          due_q[$];
	int          cyc;
	logic [1:0]  gnt_wait;
	logic        accept;

	function automatic logic [31:0] word_hash(input logic [31:0] addr);
		logic [31:0] x;
		x = {addr[31:2], 2'b00} ^ 32'h2545_f491;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		if (x[8]) x[1:0] = 2'b11; // more 32-bit instructions.
		if (x[9]) x[17:16] = 2'b11;
		return x;
	endfunction

	function automatic logic in_err_region(input logic [31:0] addr);
		return ({addr[31:2], 2'b00} >= ERR_LO) && ({addr[31:2], 2'b00} <= ERR_HI);
	endfunction

	assign accept = mem_req_i & mem_gnt_o;

	always_comb begin
		peek_lo_o = {1'b1, word_hash(peek_lo_addr_i), in_err_region(peek_lo_addr_i)};
		peek_hi_o = {1'b1, word_hash(peek_hi_addr_i), in_err_region(peek_hi_addr_i)};
	end

	// grant after 0..3 waiting cycles, response 1..4 cycles after grant, in order.
	always @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mem_gnt_o  <= 1'b0;
			mem_rsp_o  <= '0;
			inflight_o <= 0;
			gnt_wait   <= 2'b00;
			cyc        <= 0;
			addr_q.delete();
			due_q.delete();
		end else begin
			cyc        <= cyc + 1;
			inflight_o <= inflight_o + int'(accept) - int'(mem_rsp_o.valid);
			if (accept) begin
				addr_q.push_back(mem_addr_i);
				due_q.push_back(cyc + int'(rnd_i[3:2]));
				gnt_wait  <= rnd_i[1:0];
				mem_gnt_o <= (rnd_i[1:0] == 2'b00);
			end else if (mem_req_i && gnt_wait != 2'b00) begin
				gnt_wait  <= gnt_wait - 2'd1;
				mem_gnt_o <= (gnt_wait == 2'd1);
			end else begin
				mem_gnt_o <= (gnt_wait == 2'b00);
			end
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				mem_rsp_o <= {1'b1, word_hash(addr_q[0]), in_err_region(addr_q[0])};
				void'(addr_q.pop_front());
				void'(due_q.pop_front());
			end else begin
				mem_rsp_o <= '0;
			end
		end
	end

endmodule

//--- test/tb_prefetch.sv
`timescale 1ns/1ps

module tb_prefetch
	import fetch_pkg::*;
();

	localparam int          NUM_REQS  = 2;
	localparam int          NUM_TESTS = 12;
	localparam logic [31:0] ERR_LO    = 32'h0000_1040;
	localparam logic [31:0] ERR_HI    = 32'h0000_104f;

	logic        clk_i;
	logic        rst_ni;
	logic        fetch_en_i;
	logic        redirect_i;
	logic [31:0] redirect_addr_i;
	logic        out_valid_o;
	logic        out_ready_i;
	fetch_out_t  out_instr_o;
	logic        mem_req_o;
	logic [31:0] mem_addr_o;
	logic        mem_gnt_i;
	mem_rsp_t    mem_rsp_i;
	mem_rsp_t    peek_lo;
	mem_rsp_t    peek_hi;
	logic [31:0] rnd_q;
	logic [31:0] run_seed;
	logic [31:0] target [NUM_TESTS];
	int          n_instr [NUM_TESTS];
	int          cycle_limit;
	int          cycle_cnt;
	int          inflight;
	logic        en_seen;
	logic [31:0] exp_addr;
	logic [31:0] raw;
	logic [31:0] exp_instr;
	logic        exp_c;
	logic        touch_hi;
	logic        exp_err;
	logic        exp_err_plus2;
	op_class_e   exp_class;

	prefetch_top #(
		.NUM_REQS(NUM_REQS)
	) prefetch_top_i (.*);

	tb_mem_model #(
		.ERR_LO(ERR_LO),
		.ERR_HI(ERR_HI)
	) mem_model_i (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.rnd_i         (rnd_q),
		.mem_req_i     (mem_req_o),
		.mem_addr_i    (mem_addr_o),
		.mem_gnt_o     (mem_gnt_i),
		.mem_rsp_o     (mem_rsp_i),
		.inflight_o    (inflight),
		.peek_lo_addr_i({exp_addr[31:2], 2'b00}),
		.peek_hi_addr_i({exp_addr[31:2], 2'b00} + 32'd4),
		.peek_lo_o     (peek_lo),
		.peek_hi_o     (peek_hi)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic op_class_e classify(input logic [31:0] instr, input logic err);
		op_class_e cls;
		if (err) begin
			cls = OP_OTHER;
		end else if (instr[1:0] != 2'b11) begin
			cls = OP_COMPRESSED;
		end else begin
			case (instr[6:2])
				5'b00000: cls = OP_LOAD;
				5'b01000: cls = OP_STORE;
				5'b11000: cls = OP_BRANCH;
				5'b11011: cls = OP_JAL;
				5'b11001: cls = OP_JALR;
				5'b01100: cls = OP_OP;
				5'b00100: cls = OP_OP_IMM;
				5'b01101: cls = OP_LUI;
				5'b00101: cls = OP_AUIPC;
				5'b11100: cls = OP_SYSTEM;
				default:  cls = OP_OTHER;
			endcase
		end
		return cls;
	endfunction

	task automatic end_with_failure();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end_with_failure();
	endtask

	task automatic report_event(input string what);
		$display("%s", what);
		end_with_failure();
	endtask

	always #4 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		if (!rst_ni) rnd_q <= run_seed;
		else rnd_q <= xorshift32(rnd_q);
	end

	// ------------------------------------------------------------
	// reference stream
	// ------------------------------------------------------------

	always_comb begin
		raw           = exp_addr[1] ? {peek_hi.rdata[15:0], peek_lo.rdata[31:16]} : peek_lo.rdata;
		exp_c         = (raw[1:0] != 2'b11);
		exp_instr     = exp_c ? {16'h0000, raw[15:0]} : raw;
		touch_hi      = exp_addr[1] & ~exp_c; // straddles into the next word.
		exp_err       = peek_lo.err | (touch_hi & peek_hi.err);
		exp_err_plus2 = touch_hi & peek_hi.err & ~peek_lo.err;
		exp_class     = classify(exp_instr, exp_err);
	end

	always @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			exp_addr  <= '0;
			en_seen   <= 1'b0;
			cycle_cnt <= 0;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
			if (cycle_cnt >= cycle_limit) report_event("timeout, fetch stream stopped making progress");
			if (fetch_en_i) en_seen <= 1'b1;
			if (redirect_i) exp_addr <= redirect_addr_i;
			else if (out_valid_o && out_ready_i) exp_addr <= exp_addr + (exp_c ? 32'd2 : 32'd4);
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	a_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!en_seen && !fetch_en_i |-> !out_valid_o && !mem_req_o)
		else report_event("output valid or memory request before fetch was enabled");
	a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_valid_o |-> out_instr_o.addr == exp_addr)
		else report_value("out_instr_o.addr", $sampled(out_instr_o.addr), $sampled(exp_addr));
	a_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_valid_o |-> out_instr_o.instr == exp_instr)
		else report_value("out_instr_o.instr", $sampled(out_instr_o.instr), $sampled(exp_instr));
	a_class: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_valid_o |-> {out_instr_o.is_compressed, out_instr_o.op_class} == {exp_c, exp_class})
		else report_value("out_instr_o.{is_compressed,op_class}",
			32'($sampled({out_instr_o.is_compressed, out_instr_o.op_class})),
			32'($sampled({exp_c, exp_class})));
	a_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_valid_o |-> {out_instr_o.err, out_instr_o.err_plus2} == {exp_err, exp_err_plus2})
		else report_value("out_instr_o.{err,err_plus2}",
			32'($sampled({out_instr_o.err, out_instr_o.err_plus2})),
			32'($sampled({exp_err, exp_err_plus2})));
	a_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_valid_o && !out_ready_i |=> redirect_i || (out_valid_o && $stable(out_instr_o)))
		else report_event("output changed while out_ready_i was low");
	a_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
		mem_req_o |-> (inflight + $countones(prefetch_top_i.fifo_busy)) < NUM_REQS)
		else report_event("memory request made with no room left for its response");

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	initial begin
		logic [31:0] s;
		int          total;
		int          consumed;
		clk_i           = 1'b0;
		rst_ni          = 1'b0;
		fetch_en_i      = 1'b0;
		redirect_i      = 1'b0;
		redirect_addr_i = '0;
		out_ready_i     = 1'b0;
		s               = 32'd83941;
		total           = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			s = xorshift32(s);
			if (t == 0) target[t] = 32'h0000_103e; // straddles into the error window.
			else if (t == 1) target[t] = 32'h0000_104e; // leaves it.
			else target[t] = 32'h0000_1000 + ((s % 32'd56) << 1);
			s          = xorshift32(s);
			n_instr[t] = 4 + int'(s[2:0]);
			total      = total + n_instr[t];
		end
		run_seed    = xorshift32(s);
		cycle_limit = 20 * total;
		repeat (3) @(posedge clk_i);
		rst_ni <= 1'b1;
		repeat (4) @(posedge clk_i);
		fetch_en_i <= 1'b1;
		repeat (3) @(posedge clk_i);
		for (int t = 0; t < NUM_TESTS; t++) begin
			redirect_i      <= 1'b1; // requests are still in flight here.
			redirect_addr_i <= target[t];
			out_ready_i     <= (rnd_q[9:8] != 2'b00);
			@(posedge clk_i);
			redirect_i <= 1'b0;
			consumed = 0;
			while (consumed < n_instr[t]) begin
				@(posedge clk_i);
				if (out_valid_o && out_ready_i) consumed++;
				out_ready_i <= (rnd_q[9:8] != 2'b00);
			end
		end
		repeat (2) @(posedge clk_i);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- flist.f
hdl/fetch_pkg.sv
hdl/fetch_req_ctrl.sv
hdl/fetch_fifo.sv
hdl/instr_predecode.sv
hdl/prefetch_top.sv
test/tb_mem_model.sv
test/tb_prefetch.sv

//--- run.sh
#!/bin/sh
# Build and run the prefetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --assert -Wno-fatal --top-module tb_prefetch -f flist.f -o tb_prefetch_sim; then
	echo "compile step failed"
	exit 1
fi

if ! ./obj_dir/tb_prefetch_sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation returned a failing status"
	exit 1
fi
cat "$LOG"

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1
